/* post_video_macros.svh */
`ifndef POST_VIDEO_MACROS_SVH
`define POST_VIDEO_MACROS_SVH

// counter and geometry field width
`define VT_CNT_W        12

// apb bus widths
`define APB_ADDR_W      8
`define APB_DATA_W      32

// timing generator to o_post_vs/o_post_de
`define POST_IN_DELAY   5
// o_post_de to display outputs
`define POST_OUT_DELAY  4

// reset geometry, 1024x768 line and frame
`define VT_RST_H_ACTIVE 1024
`define VT_RST_H_FP     24
`define VT_RST_H_SYNC   136
`define VT_RST_H_BP     160

`define VT_RST_V_ACTIVE 768
`define VT_RST_V_FP     3
`define VT_RST_V_SYNC   6
`define VT_RST_V_BP     29

`endif

/* post_video_pkg.sv */
`default_nettype none

`include "post_video_macros.svh"

package post_video_pkg;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // all geometry fields in pixels or lines
    typedef struct packed {
        logic [`VT_CNT_W-1:0] h_active;
        logic [`VT_CNT_W-1:0] h_fp;
        logic [`VT_CNT_W-1:0] h_sync;
        logic [`VT_CNT_W-1:0] h_bp;
        logic [`VT_CNT_W-1:0] v_active;
        logic [`VT_CNT_W-1:0] v_fp;
        logic [`VT_CNT_W-1:0] v_sync;
        logic [`VT_CNT_W-1:0] v_bp;
    } video_timing_cfg_t;

    typedef struct packed {
        logic hs;   // active low
        logic vs;   // active low
        logic de;
    } video_sync_t;

    localparam video_sync_t sync_idle = '{hs: 1'b1, vs: 1'b1, de: 1'b0};

    typedef struct packed {
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
    } rgb565_t;

    typedef struct packed {
        video_sync_t sync;
        logic [7:0]  r;
        logic [7:0]  g;
        logic [7:0]  b;
    } disp_pixel_t;

endpackage

`default_nettype wire

/* video_timing_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "post_video_macros.svh"

module video_timing_regs
    import post_video_pkg::*;
(
    input  wire                      o_post_clk,
    input  wire                      rst_n,
    input  wire apb_req_t            i_apb_req,
    output apb_rsp_t                 o_apb_rsp,
    output logic                     o_enable,
    output video_timing_cfg_t        o_cfg
);

    localparam logic [`APB_ADDR_W-1:0] ADDR_CTRL     = 'h00;
    localparam logic [`APB_ADDR_W-1:0] ADDR_H_ACTIVE = 'h04;
    localparam logic [`APB_ADDR_W-1:0] ADDR_H_FP     = 'h08;
    localparam logic [`APB_ADDR_W-1:0] ADDR_H_SYNC   = 'h0c;
    localparam logic [`APB_ADDR_W-1:0] ADDR_H_BP     = 'h10;
    localparam logic [`APB_ADDR_W-1:0] ADDR_V_ACTIVE = 'h14;
    localparam logic [`APB_ADDR_W-1:0] ADDR_V_FP     = 'h18;
    localparam logic [`APB_ADDR_W-1:0] ADDR_V_SYNC   = 'h1c;
    localparam logic [`APB_ADDR_W-1:0] ADDR_V_BP     = 'h20;

    logic                   access;
    logic                   addr_hit;
    logic [`APB_DATA_W-1:0] rd_data;
    logic [`VT_CNT_W-1:0]   wr_field;

    assign access   = i_apb_req.psel & i_apb_req.penable;
    assign wr_field = i_apb_req.pwdata[`VT_CNT_W-1:0];

    // address decode and read mux
    always_comb
    begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (i_apb_req.paddr)
            ADDR_CTRL:     rd_data = `APB_DATA_W'(o_enable);
            ADDR_H_ACTIVE: rd_data = `APB_DATA_W'(o_cfg.h_active);
            ADDR_H_FP:     rd_data = `APB_DATA_W'(o_cfg.h_fp);
            ADDR_H_SYNC:   rd_data = `APB_DATA_W'(o_cfg.h_sync);
            ADDR_H_BP:     rd_data = `APB_DATA_W'(o_cfg.h_bp);
            ADDR_V_ACTIVE: rd_data = `APB_DATA_W'(o_cfg.v_active);
            ADDR_V_FP:     rd_data = `APB_DATA_W'(o_cfg.v_fp);
            ADDR_V_SYNC:   rd_data = `APB_DATA_W'(o_cfg.v_sync);
            ADDR_V_BP:     rd_data = `APB_DATA_W'(o_cfg.v_bp);
            default:       addr_hit = 1'b0;
        endcase
    end

    // no wait states
    assign o_apb_rsp.pready  = access;
    assign o_apb_rsp.pslverr = access & ~addr_hit;
    assign o_apb_rsp.prdata  = access ? rd_data : '0;

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_enable       <= 1'b0;
            o_cfg.h_active <= `VT_CNT_W'(`VT_RST_H_ACTIVE);
            o_cfg.h_fp     <= `VT_CNT_W'(`VT_RST_H_FP);
            o_cfg.h_sync   <= `VT_CNT_W'(`VT_RST_H_SYNC);
            o_cfg.h_bp     <= `VT_CNT_W'(`VT_RST_H_BP);
            o_cfg.v_active <= `VT_CNT_W'(`VT_RST_V_ACTIVE);
            o_cfg.v_fp     <= `VT_CNT_W'(`VT_RST_V_FP);
            o_cfg.v_sync   <= `VT_CNT_W'(`VT_RST_V_SYNC);
            o_cfg.v_bp     <= `VT_CNT_W'(`VT_RST_V_BP);
        end
        else if (access && i_apb_req.pwrite && addr_hit)
        begin
            case (i_apb_req.paddr)
                ADDR_CTRL:     o_enable       <= i_apb_req.pwdata[0];
                ADDR_H_ACTIVE: o_cfg.h_active <= wr_field;
                ADDR_H_FP:     o_cfg.h_fp     <= wr_field;
                ADDR_H_SYNC:   o_cfg.h_sync   <= wr_field;
                ADDR_H_BP:     o_cfg.h_bp     <= wr_field;
                ADDR_V_ACTIVE: o_cfg.v_active <= wr_field;
                ADDR_V_FP:     o_cfg.v_fp     <= wr_field;
                ADDR_V_SYNC:   o_cfg.v_sync   <= wr_field;
                default:       o_cfg.v_bp     <= wr_field;  // only V_BP left after hit
            endcase
        end
    end

endmodule

`default_nettype wire

/* video_timing_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "post_video_macros.svh"

module video_timing_gen
    import post_video_pkg::*;
(
    input  wire                      o_post_clk,
    input  wire                      rst_n,
    input  wire                      i_enable,
    input  wire video_timing_cfg_t   i_cfg,
    output video_sync_t              o_sync
);

    logic                 en_d;
    video_timing_cfg_t    cfg_q;    // geometry of the running frame
    logic [`VT_CNT_W-1:0] h_cnt;
    logic [`VT_CNT_W-1:0] v_cnt;
    logic [`VT_CNT_W-1:0] hs_start;
    logic [`VT_CNT_W-1:0] hs_end;
    logic [`VT_CNT_W-1:0] h_total;
    logic [`VT_CNT_W-1:0] vs_start;
    logic [`VT_CNT_W-1:0] vs_end;
    logic [`VT_CNT_W-1:0] v_total;
    logic                 h_last;
    logic                 v_last;
    logic                 run;
    logic                 cfg_load;

    assign hs_start = cfg_q.h_active + cfg_q.h_fp;
    assign hs_end   = hs_start + cfg_q.h_sync;
    assign h_total  = hs_end + cfg_q.h_bp;
    assign vs_start = cfg_q.v_active + cfg_q.v_fp;
    assign vs_end   = vs_start + cfg_q.v_sync;
    assign v_total  = vs_end + cfg_q.v_bp;

    assign h_last = (h_cnt == h_total - 1'b1);
    assign v_last = (v_cnt == v_total - 1'b1);

    // counting only once the latch cycle after enable rise is past
    assign run = i_enable & en_d;

    // enable rise or frame end
    assign cfg_load = i_enable & (~en_d | (h_last & v_last));

    always_ff @(posedge o_post_clk)
    begin
        if (cfg_load)
            cfg_q <= i_cfg;
    end

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            en_d   <= 1'b0;
            h_cnt  <= '0;
            v_cnt  <= '0;
            o_sync <= sync_idle;
        end
        else
        begin
            en_d <= i_enable;
            if (!run)
            begin
                h_cnt  <= '0;
                v_cnt  <= '0;
                o_sync <= sync_idle;
            end
            else
            begin
                // decode of the current counter state
                o_sync.hs <= ~((h_cnt >= hs_start) && (h_cnt < hs_end));
                o_sync.vs <= ~((v_cnt >= vs_start) && (v_cnt < vs_end));
                o_sync.de <= (h_cnt < cfg_q.h_active) && (v_cnt < cfg_q.v_active);

                if (h_last)
                begin
                    h_cnt <= '0;
                    v_cnt <= v_last ? '0 : v_cnt + 1'b1;
                end
                else
                begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sync_delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

module sync_delay_line
    import post_video_pkg::*;
#(
    parameter int DEPTH = 5
)
(
    input  wire                o_post_clk,
    input  wire                rst_n,
    input  wire video_sync_t   i_sync,
    output video_sync_t        o_sync
);

    video_sync_t stage [DEPTH];

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // idle syncs so no frame start shows up after reset
            for (int i = 0; i < DEPTH; i++)
                stage[i] <= sync_idle;
        end
        else
        begin
            stage[0] <= i_sync;
            for (int i = 1; i < DEPTH; i++)
                stage[i] <= stage[i-1];
        end
    end

    assign o_sync = stage[DEPTH-1];

endmodule

`default_nettype wire

/* capture_frame_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module capture_frame_ctrl
(
    input  wire  o_post_clk,
    input  wire  rst_n,
    input  wire  i_finish,
    input  wire  i_vs,
    output logic o_camvs
);

    // one-hot
    typedef enum logic [3:0] {
        ST_WAIT_FINISH = 4'b0001,
        ST_WAIT_LOW    = 4'b0010,
        ST_WAIT_HIGH   = 4'b0100,
        ST_WAIT_LOW2   = 4'b1000
    } cap_state_t;

    cap_state_t state;

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= ST_WAIT_FINISH;
            o_camvs <= 1'b0;
        end
        else
        begin
            case (state)
                ST_WAIT_FINISH:
                    if (i_finish)
                        state <= ST_WAIT_LOW;
                ST_WAIT_LOW:
                    if (!i_vs)
                    begin
                        state   <= ST_WAIT_HIGH;
                        o_camvs <= 1'b1;        // window opens on frame sync
                    end
                ST_WAIT_HIGH:
                    if (i_vs)
                        state <= ST_WAIT_LOW2;
                ST_WAIT_LOW2:
                    if (!i_vs)
                    begin
                        state   <= ST_WAIT_FINISH;
                        o_camvs <= 1'b0;        // next frame sync ends it
                    end
                default:
                begin
                    state   <= ST_WAIT_FINISH;
                    o_camvs <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* disp_pixel_fmt.sv */
`timescale 1ns/10ps
`default_nettype none

module disp_pixel_fmt
    import post_video_pkg::*;
(
    input  wire                o_post_clk,
    input  wire                rst_n,
    input  wire video_sync_t   i_sync,
    input  wire rgb565_t       i_pixel,
    output disp_pixel_t        o_disp
);

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_disp.sync <= sync_idle;
            o_disp.r    <= '0;
            o_disp.g    <= '0;
            o_disp.b    <= '0;
        end
        else
        begin
            o_disp.sync <= i_sync;
            if (i_sync.de)
            begin
                // low bits padded with zeros
                o_disp.r <= {i_pixel.r5, 3'b000};
                o_disp.g <= {i_pixel.g6, 2'b00};
                o_disp.b <= {i_pixel.b5, 3'b000};
            end
            else
            begin
                o_disp.r <= '0;     // blanking
                o_disp.g <= '0;
                o_disp.b <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* post_video_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "post_video_macros.svh"

module post_video_top
    import post_video_pkg::*;
(
    input  wire             o_post_clk,
    input  wire             rst_n,
    input  wire apb_req_t   i_apb_req,
    input  wire rgb565_t    i_post_data,
    input  wire             i_finish,
    output apb_rsp_t        o_apb_rsp,
    output logic            o_post_vs,
    output logic            o_post_de,
    output logic            o_post_camvs,
    output disp_pixel_t     o_disp
);

    logic              vt_enable;
    video_timing_cfg_t vt_cfg;
    video_sync_t       gen_sync;
    video_sync_t       post_sync;   // aligned with the processor input
    video_sync_t       out_sync;

    video_timing_regs u_regs (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_apb_req  (i_apb_req),
        .o_apb_rsp  (o_apb_rsp),
        .o_enable   (vt_enable),
        .o_cfg      (vt_cfg)
    );

    video_timing_gen u_gen (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_enable   (vt_enable),
        .i_cfg      (vt_cfg),
        .o_sync     (gen_sync)
    );

    sync_delay_line #(.DEPTH(`POST_IN_DELAY)) u_in_dly (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_sync     (gen_sync),
        .o_sync     (post_sync)
    );

    assign o_post_vs = post_sync.vs;
    assign o_post_de = post_sync.de;

    // last out stage is the formatter register
    sync_delay_line #(.DEPTH(`POST_OUT_DELAY - 1)) u_out_dly (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_sync     (post_sync),
        .o_sync     (out_sync)
    );

    capture_frame_ctrl u_cap (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_finish   (i_finish),
        .i_vs       (post_sync.vs),
        .o_camvs    (o_post_camvs)
    );

    disp_pixel_fmt u_fmt (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_sync     (out_sync),
        .i_pixel    (i_post_data),
        .o_disp     (o_disp)
    );

endmodule

`default_nettype wire

/* post_video_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module post_video_sva
    import post_video_pkg::*;
(
    input wire              o_post_clk,
    input wire              rst_n,
    input wire apb_req_t    i_apb_req,
    input wire apb_rsp_t    i_apb_rsp,
    input wire disp_pixel_t i_disp,
    input wire              i_camvs,
    input wire              i_finish
);

    int   fail_cnt = 0;
    logic camvs_d;
    logic finish_seen;  // finish since the last window opened
    logic unmapped;

    // map is 0x00 to 0x20 on word addresses
    assign unmapped = (i_apb_req.paddr > 8'h20) || (i_apb_req.paddr[1:0] != 2'b00);

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            camvs_d     <= 1'b0;
            finish_seen <= 1'b0;
        end
        else
        begin
            camvs_d <= i_camvs;
            if (i_camvs && !camvs_d)
                finish_seen <= 1'b0;
            else if (i_finish && !i_camvs)
                finish_seen <= 1'b1;
        end
    end

    a_slverr_ready: assert property (@(posedge o_post_clk) disable iff (!rst_n)
        i_apb_rsp.pslverr |-> (i_apb_rsp.pready && unmapped))
    else
    begin
        fail_cnt++;
        $error("pslverr high without pready or on a mapped address");
    end

    a_disp_blank: assert property (@(posedge o_post_clk) disable iff (!rst_n)
        !i_disp.sync.de |-> (i_disp.r == 8'h00 && i_disp.g == 8'h00 && i_disp.b == 8'h00))
    else
    begin
        fail_cnt++;
        $error("display pixel not blanked outside the active area");
    end

    a_camvs_rise: assert property (@(posedge o_post_clk) disable iff (!rst_n)
        (i_camvs && !camvs_d) |-> finish_seen)
    else
    begin
        fail_cnt++;
        $error("capture window opened without a finish request");
    end

endmodule

`default_nettype wire

/* tb_post_video.sv */
`timescale 1ns/10ps
`default_nettype none

`include "post_video_macros.svh"

module tb_post_video
    import post_video_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int MAX_FRAME   = 48 * 48;   // every field at 12
    localparam int TEST_FRAMES = 7;
    localparam int REG_CYCLES  = 40 * 3;
    localparam int TIMEOUT_CYC = TEST_FRAMES * MAX_FRAME + REG_CYCLES + 1000;

    localparam video_timing_cfg_t RST_GEO = '{`VT_RST_H_ACTIVE, `VT_RST_H_FP, `VT_RST_H_SYNC,
        `VT_RST_H_BP, `VT_RST_V_ACTIVE, `VT_RST_V_FP, `VT_RST_V_SYNC, `VT_RST_V_BP};

    logic        o_post_clk;
    logic        rst_n;
    apb_req_t    i_apb_req;
    rgb565_t     i_post_data;
    logic        i_finish;
    apb_rsp_t    o_apb_rsp;
    logic        o_post_vs;
    logic        o_post_de;
    logic        o_post_camvs;
    disp_pixel_t o_disp;

    integer            seed;
    logic [31:0]       upper_junk;
    video_timing_cfg_t geo_a;
    video_timing_cfg_t geo_b;
    video_timing_cfg_t cur_cfg;
    video_timing_cfg_t next_cfg;    // takes over at the next frame boundary
    int                rewrite_dly;
    logic              checks_on;
    logic              armed;
    logic              aligned;
    int                h_pos;
    int                v_pos;
    int                frame_cnt;
    int                cycle_cnt;
    int                cam_state;
    logic              exp_camvs;
    int                cam_windows;
    video_sync_t       sync_hist[$];    // expected o_post syncs of the last four cycles

    post_video_top uut (
        .o_post_clk   (o_post_clk),
        .rst_n        (rst_n),
        .i_apb_req    (i_apb_req),
        .i_post_data  (i_post_data),
        .i_finish     (i_finish),
        .o_apb_rsp    (o_apb_rsp),
        .o_post_vs    (o_post_vs),
        .o_post_de    (o_post_de),
        .o_post_camvs (o_post_camvs),
        .o_disp       (o_disp)
    );

    bind post_video_top post_video_sva u_sva (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_apb_req  (i_apb_req),
        .i_apb_rsp  (o_apb_rsp),
        .i_disp     (o_disp),
        .i_camvs    (o_post_camvs),
        .i_finish   (i_finish)
    );

    always #(CLK_PERIOD / 2) o_post_clk = ~o_post_clk;

    function automatic int line_len(video_timing_cfg_t c);
        return c.h_active + c.h_fp + c.h_sync + c.h_bp;
    endfunction

    function automatic int frame_len(video_timing_cfg_t c);
        return c.v_active + c.v_fp + c.v_sync + c.v_bp;
    endfunction

    function automatic logic [`VT_CNT_W-1:0] field_of(video_timing_cfg_t g, int idx);
        logic [$bits(video_timing_cfg_t)-1:0] flat;
        flat = g;
        return flat[(7 - idx) * `VT_CNT_W +: `VT_CNT_W];
    endfunction

    // expected sync at a line and frame position
    function automatic video_sync_t expected_sync(int h, int v, video_timing_cfg_t c);
        video_sync_t s;
        int          hs0;
        int          vs0;
        hs0  = c.h_active + c.h_fp;
        vs0  = c.v_active + c.v_fp;
        s.hs = !(h >= hs0 && h < hs0 + c.h_sync);
        s.vs = !(v >= vs0 && v < vs0 + c.v_sync);
        s.de = (h < c.h_active) && (v < c.v_active);
        return s;
    endfunction

    function automatic disp_pixel_t expected_disp(video_sync_t s, rgb565_t p);
        disp_pixel_t d;
        d.sync = s;
        d.r    = s.de ? {p.r5, 3'b000} : 8'h00;
        d.g    = s.de ? {p.g6, 2'b00} : 8'h00;
        d.b    = s.de ? {p.b5, 3'b000} : 8'h00;
        return d;
    endfunction

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_bit(string name, logic exp, logic act);
        if (act !== exp)
            report_error($sformatf("Error: %0t ns %s expected %b actual %b", $time, name, exp, act));
    endtask

    task automatic compare_disp(string name, disp_pixel_t exp, disp_pixel_t act);
        if (act !== exp)
            report_error($sformatf("Error: %0t ns %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic compare_apb(string name, apb_rsp_t exp, apb_rsp_t act);
        if (act !== exp)
            report_error($sformatf("Error: %0t ns %s expected %h actual %h", $time, name, exp, act));
    endtask

    // small random geometry with room for a whole rewrite in one frame
    task automatic make_geometry(output video_timing_cfg_t g);
        g = '0;
        while (line_len(g) * frame_len(g) < 64)
        begin
            g.h_active = 2 + {$random(seed)} % 11;
            g.h_fp     = 1 + {$random(seed)} % 12;
            g.h_sync   = 1 + {$random(seed)} % 12;
            g.h_bp     = 1 + {$random(seed)} % 12;
            g.v_active = 2 + {$random(seed)} % 11;
            g.v_fp     = 1 + {$random(seed)} % 12;
            g.v_sync   = 1 + {$random(seed)} % 12;
            g.v_bp     = 1 + {$random(seed)} % 12;
        end
    endtask

    task automatic apb_access(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [`APB_DATA_W-1:0] wdata, output apb_rsp_t rsp);
        @(negedge o_post_clk);
        i_apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge o_post_clk);
        i_apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);  // mid access phase
        rsp = o_apb_rsp;
        @(negedge o_post_clk);
        i_apb_req = '0;
        if (rsp.pready !== 1'b1)
            report_error($sformatf("pready was not high in the access phase at address %h", addr));
    endtask

    task automatic write_geometry(video_timing_cfg_t g);
        apb_rsp_t rsp;
        for (int i = 0; i < 8; i++)
            apb_access(1'b1, `APB_ADDR_W'(4 * (i + 1)),
                       {upper_junk[31:`VT_CNT_W], field_of(g, i)}, rsp);
    endtask

    task automatic check_geometry(video_timing_cfg_t g);
        apb_rsp_t rsp;
        apb_rsp_t exp;
        for (int i = 0; i < 8; i++)
        begin
            apb_access(1'b0, `APB_ADDR_W'(4 * (i + 1)), '0, rsp);
            exp = '{prdata: `APB_DATA_W'(field_of(g, i)), pready: 1'b1, pslverr: 1'b0};
            compare_apb($sformatf("o_apb_rsp@%02h", 4 * (i + 1)), exp, rsp);
        end
    endtask

    task automatic advance_position();
        if (h_pos == line_len(cur_cfg) - 1)
        begin
            h_pos = 0;
            if (v_pos == frame_len(cur_cfg) - 1)
            begin
                v_pos     = 0;
                cur_cfg   = next_cfg;
                frame_cnt = frame_cnt + 1;
            end
            else
                v_pos = v_pos + 1;
        end
        else
            h_pos = h_pos + 1;
    endtask

    // capture window rule on the fin and vs that the DUT samples next
    task automatic update_camvs(logic fin, logic vs);
        case (cam_state)
            0: if (fin) cam_state = 1;
            1: if (!vs)
               begin
                   cam_state   = 2;
                   exp_camvs   = 1'b1;
                   cam_windows = cam_windows + 1;
               end
            2: if (vs) cam_state = 3;
            default: if (!vs)
               begin
                   cam_state = 0;
                   exp_camvs = 1'b0;
               end
        endcase
    endtask

    always @(negedge o_post_clk)
    begin
        video_sync_t exp_sync;
        logic [31:0] rnd;
        if (checks_on)
        begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > TIMEOUT_CYC)
                report_error("timeout, the run went past its cycle limit");
            if (uut.u_sva.fail_cnt != 0)
                report_error("a bound assertion on the DUT failed");
            if (!aligned && armed && o_post_de)
            begin
                aligned   = 1'b1;   // first frame start
                h_pos     = 0;
                v_pos     = 0;
                cur_cfg   = next_cfg;
                frame_cnt = 1;
            end
            exp_sync = aligned ? expected_sync(h_pos, v_pos, cur_cfg) : sync_idle;
            compare_bit("o_post_vs", exp_sync.vs, o_post_vs);
            compare_bit("o_post_de", exp_sync.de, o_post_de);
            compare_disp("o_disp", expected_disp(sync_hist.pop_front(), i_post_data), o_disp);
            sync_hist.push_back(exp_sync);
            compare_bit("o_post_camvs", exp_camvs, o_post_camvs);
            if (aligned)
                advance_position();
        end
        // processor returns a fresh pixel every cycle
        rnd         = $random(seed);
        i_post_data = rnd[15:0];
        rnd         = $random(seed);
        i_finish    = armed && (rnd % 50 == 0);
        if (checks_on)
            update_camvs(i_finish, exp_sync.vs);
    end

    initial
    begin
        apb_rsp_t rsp;
        apb_rsp_t exp;
        o_post_clk  = 1'b0;
        rst_n       = 1'b0;
        i_apb_req   = '0;
        i_post_data = '0;
        i_finish    = 1'b0;
        checks_on   = 1'b0;
        armed       = 1'b0;
        aligned     = 1'b0;
        h_pos       = 0;
        v_pos       = 0;
        frame_cnt   = 0;
        cycle_cnt   = 0;
        cam_state   = 0;
        exp_camvs   = 1'b0;
        cam_windows = 0;
        for (int i = 0; i < `POST_OUT_DELAY; i++)
            sync_hist.push_back(sync_idle);
        seed        = 32'h3070_19f5;
        upper_junk  = $random(seed);
        make_geometry(geo_a);
        make_geometry(geo_b);
        rewrite_dly = {$random(seed)} % 8;
        next_cfg    = geo_a;
        cur_cfg     = geo_a;

        repeat (8) @(negedge o_post_clk);
        rst_n = 1'b1;
        @(posedge o_post_clk);
        checks_on = 1'b1;

        apb_access(1'b0, 'h00, '0, rsp);
        exp = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
        compare_apb("o_apb_rsp@00", exp, rsp);
        check_geometry(RST_GEO);
        apb_access(1'b0, 'h24, '0, rsp);   // unmapped
        exp = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
        compare_apb("o_apb_rsp@24", exp, rsp);

        write_geometry(geo_a);
        check_geometry(geo_a);
        @(posedge o_post_clk);
        armed = 1'b1;
        apb_access(1'b1, 'h00, 32'h1, rsp);

        // rewrite early in the third frame
        wait (frame_cnt == 3);
        repeat (rewrite_dly) @(posedge o_post_clk);
        next_cfg = geo_b;
        write_geometry(geo_b);
        wait (frame_cnt == 6);

        if (cam_windows == 0)
            report_error("no capture window opened during the run");
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
post_video_pkg.sv
video_timing_regs.sv
video_timing_gen.sv
sync_delay_line.sv
capture_frame_ctrl.sv
disp_pixel_fmt.sv
post_video_top.sv
post_video_sva.sv
tb_post_video.sv
